// ==== tb.f ====
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_align.sv
verilog/lsu_axi_master.sv
verilog/axil_data_ram.sv
verilog/lsu_top.sv
testbench/lsu_properties.sv
testbench/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= lsu_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_tb;
  import lsu_pkg::*;

  localparam int          CLK_PERIOD = 8;
  localparam int          NUM_RANDOM = 400;
  localparam int          MAX_WAIT   = 20;
  localparam int unsigned SEED       = 32'he9513045;
  localparam addr_t       RAM_BASE   = `LSU_RAM_BASE;
  localparam int          RAM_BYTES  = `LSU_RAM_WORDS * 8;
  localparam int          TIMEOUT_NS = NUM_RANDOM * MAX_WAIT * CLK_PERIOD;

  logic  clk;
  logic  reset;
  logic  req_valid;
  logic  req_write;
  size_t req_size;
  logic  req_unsigned;
  addr_t req_addr;
  data_t req_wdata;
  logic  req_ready;
  logic  resp_valid;
  data_t resp_rdata;
  logic  resp_fault;

  bit run_done;
  bit fail_reported;

  // byte model, bit 8 marks a written byte
  logic [8:0] model_mem [addr_t];

  lsu_top i_lsu_top (
    .clk          (clk),
    .reset        (reset),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_size     (req_size),
    .req_unsigned (req_unsigned),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_ready    (req_ready),
    .resp_valid   (resp_valid),
    .resp_rdata   (resp_rdata),
    .resp_fault   (resp_fault)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    fail_reported = 1'b1;
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s returned data %h, expected %h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_fault(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s returned fault %b, expected %b",
                          $time, what, got, exp));
    end
  endtask

  function automatic int size_bytes(input size_t size);
    return 1 << size;
  endfunction

  function automatic bit model_known(input addr_t addr, input int nbytes);
    addr_t a;
    for (int i = 0; i < nbytes; i++) begin
      a = addr + addr_t'(i);
      if (!model_mem.exists(a) || !model_mem[a][8]) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic void model_store(input addr_t addr, input int nbytes, input data_t data);
    for (int i = 0; i < nbytes; i++) begin
      model_mem[addr + addr_t'(i)] = {1'b1, data[8*i +: 8]};
    end
  endfunction

  // little endian bytes, then extension from the top bit of the size
  function automatic data_t model_load(input addr_t addr, input size_t size,
                                       input logic is_unsigned);
    data_t value;
    int    nbytes;
    logic  sign;
    value  = '0;
    nbytes = size_bytes(size);
    for (int i = 0; i < nbytes; i++) begin
      value[8*i +: 8] = model_mem[addr + addr_t'(i)][7:0];
    end
    sign = value[8*nbytes-1] & ~is_unsigned;
    for (int i = 8 * nbytes; i < 64; i++) begin
      value[i] = sign;
    end
    return value;
  endfunction

  // kind 0 aligned in window, 1 misaligned in window, 2 outside the window
  function automatic addr_t pick_addr(input int kind, input size_t size);
    int nbytes;
    int word;
    int offset;
    nbytes = size_bytes(size);
    // small working set at the bottom plus the last words of the window
    if ($urandom_range(0, 3) == 0) word = `LSU_RAM_WORDS - 1 - $urandom_range(0, 7);
    else word = $urandom_range(0, 15);
    offset = $urandom_range(0, 7);
    if (kind == 1) begin
      if (offset % nbytes == 0) offset = offset | 1;
    end else begin
      offset = offset & ~(nbytes - 1);
    end
    if (kind != 2) return RAM_BASE + addr_t'(word * 8 + offset);
    if ($urandom_range(0, 1) == 0) begin
      return RAM_BASE + addr_t'(RAM_BYTES) + addr_t'(8 * $urandom_range(0, 4095) + offset);
    end
    return addr_t'(8 * $urandom_range(0, 1 << 20) + offset);
  endfunction

  task automatic run_request(input logic write, input size_t size, input logic is_unsigned,
                             input addr_t addr, input data_t wdata,
                             output data_t rdata, output logic fault, output int latency);
    while (!req_ready) @(negedge clk);
    req_valid    = 1'b1;
    req_write    = write;
    req_size     = size;
    req_unsigned = is_unsigned;
    req_addr     = addr;
    req_wdata    = wdata;
    @(negedge clk);
    req_valid = 1'b0;
    latency   = 1;
    while (!resp_valid) begin
      if (latency >= MAX_WAIT) abort_run("no response from the LSU within the allowed cycles");
      @(negedge clk);
      latency++;
    end
    rdata = resp_rdata;
    fault = resp_fault;
    @(negedge clk);
    if (resp_valid) abort_run("resp_valid lasted longer than one cycle");
  endtask

  initial begin
    #(TIMEOUT_NS);
    abort_run($sformatf("run timed out after %0d ns", TIMEOUT_NS));
  end

  // a failing assertion may end the run before the request loop completes
  final begin
    if (!run_done && !fail_reported) begin
      $display("run ended early, stopped by a failing assertion");
      $display("Simulation failed");
    end
  end

  initial begin
    data_t rdata;
    data_t wdata;
    logic  fault;
    logic  do_write;
    logic  is_unsigned;
    size_t size;
    addr_t addr;
    addr_t word_addr;
    int    latency;
    int    pick;
    int    kind;
    int    nbytes;

    void'($urandom(SEED));
    reset        = 1'b1;
    req_valid    = 1'b0;
    req_write    = 1'b0;
    req_size     = SIZE_BYTE;
    req_unsigned = 1'b0;
    req_addr     = '0;
    req_wdata    = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (!req_ready || resp_valid) begin
      abort_run("after reset req_ready should be high and resp_valid low");
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      pick        = $urandom_range(0, 99);
      kind        = (pick < 70) ? 0 : (pick < 85) ? 1 : 2;
      do_write    = 1'($urandom_range(0, 1));
      is_unsigned = 1'($urandom_range(0, 1));
      if (kind == 1) size = size_t'($urandom_range(1, 3));
      else size = size_t'($urandom_range(0, 3));
      addr   = pick_addr(kind, size);
      wdata  = {$urandom(), $urandom()};
      nbytes = size_bytes(size);
      run_request(do_write, size, is_unsigned, addr, wdata, rdata, fault, latency);
      case (kind)
        0: begin
          check_fault(fault, 1'b0, "aligned access");
          if (do_write) begin
            check_data(rdata, '0, "aligned store");
            model_store(addr, nbytes, wdata);
          end else if (model_known(addr, nbytes)) begin
            check_data(rdata, model_load(addr, size, is_unsigned), "aligned load");
          end
        end
        1: begin
          check_fault(fault, 1'b1, "misaligned access");
          check_data(rdata, '0, "misaligned access");
          if (latency != 1) begin
            abort_run("misaligned request did not respond one cycle after acceptance");
          end
          if (do_write) begin
            // the whole word must still match the model
            word_addr = {addr[31:3], 3'b000};
            run_request(1'b0, SIZE_DOUBLE, 1'b0, word_addr, '0, rdata, fault, latency);
            check_fault(fault, 1'b0, "load after misaligned store");
            if (model_known(word_addr, 8)) begin
              check_data(rdata, model_load(word_addr, SIZE_DOUBLE, 1'b0),
                         "load after misaligned store");
            end
          end
        end
        default: begin
          check_fault(fault, 1'b1, "access outside the RAM window");
          check_data(rdata, '0, "access outside the RAM window");
        end
      endcase
    end

    run_done = 1'b1;
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== testbench/lsu_properties.sv ====
`timescale 1ns/1ps

module lsu_properties (
  input logic                clk,
  input logic                reset,
  input lsu_pkg::lsu_state_t state,
  input logic                req_valid,
  input logic                req_ready,
  input logic                resp_valid,
  input lsu_pkg::addr_t      awaddr,
  input logic                awvalid,
  input logic                awready,
  input lsu_pkg::data_t      wdata,
  input lsu_pkg::strb_t      wstrb,
  input logic                wvalid,
  input logic                wready,
  input logic                bready,
  input lsu_pkg::addr_t      araddr,
  input logic                arvalid,
  input logic                arready,
  input logic                rready
);
  import lsu_pkg::*;

  // payload stays put until the slave takes it
  aw_hold: assert property (@(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awvalid dropped or awaddr changed before awready");

  w_hold: assert property (@(posedge clk) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else $error("wvalid dropped or write data changed before wready");

  ar_hold: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid dropped or araddr changed before arready");

  // a request taken in IDLE always moves the sequencer on
  accept_leaves_idle: assert property (@(posedge clk) disable iff (reset)
    state == IDLE && req_valid |=> !req_ready)
    else $error("req_ready still high after a request was taken in IDLE");

  resp_single: assert property (@(posedge clk) disable iff (reset)
    resp_valid |=> !resp_valid)
    else $error("resp_valid held for two cycles");

  // everything quiet once reset has been applied
  after_reset: assert property (@(posedge clk)
    reset |=> !awvalid && !wvalid && !arvalid && !bready && !rready && !resp_valid)
    else $error("bus or response activity in the cycle after reset");

endmodule

bind lsu_axi_master lsu_properties i_lsu_properties (
  .clk        (clk),
  .reset      (reset),
  .state      (state),
  .req_valid  (req_valid),
  .req_ready  (req_ready),
  .resp_valid (resp_valid),
  .awaddr     (awaddr),
  .awvalid    (awvalid),
  .awready    (awready),
  .wdata      (wdata),
  .wstrb      (wstrb),
  .wvalid     (wvalid),
  .wready     (wready),
  .bready     (bready),
  .araddr     (araddr),
  .arvalid    (arvalid),
  .arready    (arready),
  .rready     (rready)
);

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
  input  logic           clk,
  input  logic           reset,
  input  logic           req_valid,
  input  logic           req_write,
  input  lsu_pkg::size_t req_size,
  input  logic           req_unsigned,
  input  lsu_pkg::addr_t req_addr,
  input  lsu_pkg::data_t req_wdata,
  output logic           req_ready,
  output logic           resp_valid,
  output lsu_pkg::data_t resp_rdata,
  output logic           resp_fault
);
  import lsu_pkg::*;

  // aligner links
  addr_t cur_addr;
  size_t cur_size;
  logic  cur_unsigned;
  data_t cur_wdata;
  strb_t strb;
  data_t lane_wdata;
  data_t load_data;
  logic  misaligned;

  // AXI4-Lite bus
  addr_t     awaddr;
  logic      awvalid;
  logic      awready;
  data_t     wdata;
  strb_t     wstrb;
  logic      wvalid;
  logic      wready;
  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;
  addr_t     araddr;
  logic      arvalid;
  logic      arready;
  data_t     rdata;
  axi_resp_t rresp;
  logic      rvalid;
  logic      rready;

  lsu_align i_lsu_align (
    .addr        (cur_addr),
    .size        (cur_size),
    .is_unsigned (cur_unsigned),
    .wdata       (cur_wdata),
    .bus_rdata   (rdata),
    .strb        (strb),
    .lane_wdata  (lane_wdata),
    .load_data   (load_data),
    .misaligned  (misaligned)
  );

  lsu_axi_master i_lsu_axi_master (
    .clk          (clk),
    .reset        (reset),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_size     (req_size),
    .req_unsigned (req_unsigned),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_ready    (req_ready),
    .resp_valid   (resp_valid),
    .resp_rdata   (resp_rdata),
    .resp_fault   (resp_fault),
    .strb         (strb),
    .lane_wdata   (lane_wdata),
    .load_data    (load_data),
    .misaligned   (misaligned),
    .cur_addr     (cur_addr),
    .cur_size     (cur_size),
    .cur_unsigned (cur_unsigned),
    .cur_wdata    (cur_wdata),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready)
  );

  axil_data_ram i_axil_data_ram (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

endmodule

// ==== verilog/axil_data_ram.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module axil_data_ram #(
  parameter int unsigned WORDS = `LSU_RAM_WORDS
) (
  input  logic               clk,
  input  logic               reset,
  // write address and data
  input  lsu_pkg::addr_t     awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  lsu_pkg::data_t     wdata,
  input  lsu_pkg::strb_t     wstrb,
  input  logic               wvalid,
  output logic               wready,
  // write response
  output lsu_pkg::axi_resp_t bresp,
  output logic               bvalid,
  input  logic               bready,
  // read address and data
  input  lsu_pkg::addr_t     araddr,
  input  logic               arvalid,
  output logic               arready,
  output lsu_pkg::data_t     rdata,
  output lsu_pkg::axi_resp_t rresp,
  output logic               rvalid,
  input  logic               rready
);
  import lsu_pkg::*;

  localparam int unsigned IDX_W  = $clog2(WORDS);
  localparam addr_t RAM_BASE  = `LSU_RAM_BASE;
  localparam addr_t RAM_BYTES = addr_t'(WORDS * 8);

  data_t            mem [WORDS];
  addr_t            aw_off;
  addr_t            ar_off;
  logic             aw_in;
  logic             ar_in;
  logic [IDX_W-1:0] aw_idx;
  logic [IDX_W-1:0] ar_idx;
  logic             wr_fire;
  logic             rd_fire;

  // window check by offset from the base
  assign aw_off = awaddr - RAM_BASE;
  assign ar_off = araddr - RAM_BASE;
  assign aw_in  = aw_off < RAM_BYTES;
  assign ar_in  = ar_off < RAM_BYTES;
  assign aw_idx = aw_off[IDX_W+2:3];
  assign ar_idx = ar_off[IDX_W+2:3];

  // address and data taken together, only with no B pending
  assign awready = awvalid && wvalid && !bvalid;
  assign wready  = awready;
  assign arready = !rvalid;

  assign wr_fire = awvalid && awready;
  assign rd_fire = arvalid && arready;

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_fire) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rd_fire) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  // response codes and read word
  always_ff @(posedge clk) begin
    if (wr_fire) bresp <= aw_in ? RESP_OKAY : RESP_SLVERR;
    if (rd_fire) begin
      rresp <= ar_in ? RESP_OKAY : RESP_SLVERR;
      rdata <= ar_in ? mem[ar_idx] : '0;
    end
  end

  // strobed byte writes, dropped outside the window
  always_ff @(posedge clk) begin
    if (wr_fire && aw_in) begin
      for (int i = 0; i < 8; i++) begin
        if (wstrb[i]) mem[aw_idx][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

endmodule

// ==== verilog/lsu_axi_master.sv ====
`timescale 1ns/1ps

module lsu_axi_master (
  input  logic               clk,
  input  logic               reset,
  // pipeline request and response
  input  logic               req_valid,
  input  logic               req_write,
  input  lsu_pkg::size_t     req_size,
  input  logic               req_unsigned,
  input  lsu_pkg::addr_t     req_addr,
  input  lsu_pkg::data_t     req_wdata,
  output logic               req_ready,
  output logic               resp_valid,
  output lsu_pkg::data_t     resp_rdata,
  output logic               resp_fault,
  // aligner
  input  lsu_pkg::strb_t     strb,
  input  lsu_pkg::data_t     lane_wdata,
  input  lsu_pkg::data_t     load_data,
  input  logic               misaligned,
  output lsu_pkg::addr_t     cur_addr,
  output lsu_pkg::size_t     cur_size,
  output logic               cur_unsigned,
  output lsu_pkg::data_t     cur_wdata,
  // AXI4-Lite master
  output lsu_pkg::addr_t     awaddr,
  output logic               awvalid,
  input  logic               awready,
  output lsu_pkg::data_t     wdata,
  output lsu_pkg::strb_t     wstrb,
  output logic               wvalid,
  input  logic               wready,
  input  lsu_pkg::axi_resp_t bresp,
  input  logic               bvalid,
  output logic               bready,
  output lsu_pkg::addr_t     araddr,
  output logic               arvalid,
  input  logic               arready,
  input  lsu_pkg::axi_resp_t rresp,
  input  logic               rvalid,
  output logic               rready
);
  import lsu_pkg::*;

  lsu_state_t state, state_next;
  addr_t      addr_q;
  size_t      size_q;
  logic       unsigned_q;
  data_t      wdata_q;
  data_t      rdata_q;
  logic       fault_q;
  logic       aw_done;
  logic       w_done;
  logic       accept;

  assign req_ready = (state == IDLE);
  assign accept    = req_valid && req_ready;

  // while idle the aligner sees the incoming request,
  // so a misaligned one is known on the accepting edge
  assign cur_addr     = (state == IDLE) ? req_addr : addr_q;
  assign cur_size     = (state == IDLE) ? req_size : size_q;
  assign cur_unsigned = (state == IDLE) ? req_unsigned : unsigned_q;
  assign cur_wdata    = (state == IDLE) ? req_wdata : wdata_q;

  // bus addresses are word aligned
  assign awaddr  = {addr_q[31:3], 3'b000};
  assign araddr  = {addr_q[31:3], 3'b000};
  assign wdata   = lane_wdata;
  assign wstrb   = strb;
  assign awvalid = (state == WRITE_ADDR) && !aw_done;
  assign wvalid  = (state == WRITE_ADDR) && !w_done;
  assign bready  = (state == WRITE_RESP);
  assign arvalid = (state == READ_ADDR);
  assign rready  = (state == READ_DATA);

  assign resp_valid = (state == RESPOND);
  assign resp_rdata = rdata_q;
  assign resp_fault = fault_q;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_valid) begin
          if (misaligned) state_next = RESPOND;
          else if (req_write) state_next = WRITE_ADDR;
          else state_next = READ_ADDR;
        end
      end
      WRITE_ADDR: begin
        // AW and W may be taken in different cycles by other slaves
        if ((aw_done || awready) && (w_done || wready)) state_next = WRITE_RESP;
      end
      WRITE_RESP: if (bvalid) state_next = RESPOND;
      READ_ADDR:  if (arready) state_next = READ_DATA;
      READ_DATA:  if (rvalid) state_next = RESPOND;
      default:    state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
      fault_q <= 1'b0;
      rdata_q <= '0;
    end else begin
      state   <= state_next;
      aw_done <= (state_next == WRITE_ADDR) && (aw_done || (awvalid && awready));
      w_done  <= (state_next == WRITE_ADDR) && (w_done || (wvalid && wready));
      if (accept) begin
        fault_q <= misaligned;
        rdata_q <= '0;
      end
      if (bvalid && bready) fault_q <= (bresp != RESP_OKAY);
      if (rvalid && rready) begin
        fault_q <= (rresp != RESP_OKAY);
        rdata_q <= (rresp == RESP_OKAY) ? load_data : '0;
      end
    end
  end

  // request payload, held for the whole transaction
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q     <= req_addr;
      size_q     <= req_size;
      unsigned_q <= req_unsigned;
      wdata_q    <= req_wdata;
    end
  end

endmodule

// ==== verilog/lsu_align.sv ====
`timescale 1ns/1ps

module lsu_align (
  input  lsu_pkg::addr_t addr,
  input  lsu_pkg::size_t size,
  input  logic           is_unsigned,
  input  lsu_pkg::data_t wdata,
  input  lsu_pkg::data_t bus_rdata,
  output lsu_pkg::strb_t strb,
  output lsu_pkg::data_t lane_wdata,
  output lsu_pkg::data_t load_data,
  output logic           misaligned
);
  import lsu_pkg::*;

  logic [2:0] offset;
  logic [5:0] shamt;
  strb_t      size_mask;
  data_t      lane_mask;
  data_t      shifted;

  // byte offset inside the 64-bit word
  assign offset = addr[2:0];
  assign shamt  = {offset, 3'b000};

  always_comb begin
    case (size)
      SIZE_BYTE: begin
        size_mask  = 8'h01;
        misaligned = 1'b0;
      end
      SIZE_HALF: begin
        size_mask  = 8'h03;
        misaligned = offset[0];
      end
      SIZE_WORD: begin
        size_mask  = 8'h0f;
        misaligned = |offset[1:0];
      end
      default: begin
        size_mask  = 8'hff;
        misaligned = |offset;
      end
    endcase
  end

  // no lanes at all for a misaligned access
  assign strb = misaligned ? '0 : strb_t'(size_mask << offset);

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      lane_mask[8*i +: 8] = {8{strb[i]}};
    end
  end

  // store data moves up onto its lanes
  assign lane_wdata = wdata << shamt;

  // pick the selected bytes, bring them down to bit 0
  assign shifted = (bus_rdata & lane_mask) >> shamt;

  always_comb begin
    case (size)
      SIZE_BYTE: load_data = {{56{~is_unsigned & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: load_data = {{48{~is_unsigned & shifted[15]}}, shifted[15:0]};
      SIZE_WORD: load_data = {{32{~is_unsigned & shifted[31]}}, shifted[31:0]};
      default:   load_data = shifted;
    endcase
  end

endmodule

// ==== verilog/lsu_pkg.sv ====
`include "lsu_config.svh"

package lsu_pkg;

  typedef logic [`LSU_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`LSU_DATA_WIDTH-1:0]   data_t;
  typedef logic [`LSU_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [1:0]                   size_t;
  typedef logic [1:0]                   axi_resp_t;

  // access size codes
  localparam size_t SIZE_BYTE   = 2'd0;
  localparam size_t SIZE_HALF   = 2'd1;
  localparam size_t SIZE_WORD   = 2'd2;
  localparam size_t SIZE_DOUBLE = 2'd3;

  // axi response codes in use
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // bus sequencer states
  typedef enum logic [2:0] {
    IDLE,
    WRITE_ADDR,
    WRITE_RESP,
    READ_ADDR,
    READ_DATA,
    RESPOND
  } lsu_state_t;

endpackage

// ==== include/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// byte address and bus word widths
`define LSU_ADDR_WIDTH 32
`define LSU_DATA_WIDTH 64

// data RAM geometry, in 64-bit words
`define LSU_RAM_WORDS 512

// RAM starts at the usual reset region of the core
`define LSU_RAM_BASE 32'h8000_0000

`endif
